// ==== list.f ====
source/dispatch_pkg.sv
source/sync_fifo.sv
source/word_assembler.sv
source/dispatcher.sv
source/dest_router.sv
source/dispatch_top.sv
tb/dispatch_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = dispatch_tb
FLIST    = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/dispatch_tb.sv ====
`timescale 1ns/100ps

module dispatch_tb;

	import dispatch_pkg::*;

	localparam int data_w     = 128;
	localparam int fifo_depth = 16;
	localparam int port_count = 4;
	localparam int byte_w     = data_w / lanes_per_flit;
	localparam int clk_period = 20;
	localparam int n_flits    = 3000;
	localparam int stall_at   = 1000; // Accepted flits before the long stall
	localparam int stall_len  = 300;
	localparam longint run_limit = longint'(n_flits) * 16 * clk_period;

	logic                  clk = 1'b0;
	logic                  rst;
	logic [byte_w-1:0]     host_wdata;
	logic                  host_wen;
	logic                  host_rdy;
	logic [port_count-1:0] out_valid;
	logic [port_count-1:0] out_ready;
	logic [data_w-1:0]     out_data;
	logic [meta_w-1:0]     out_id;
	logic [meta_w-1:0]     out_dest;
	logic [byte_w-1:0]     out_keep;
	logic [byte_w-1:0]     out_strb;
	logic [user_w-1:0]     out_user;
	logic                  out_last;

	logic [31:0] rng;
	logic        stalling;
	int          stall_left;

	// Reference model state
	logic [byte_w-1:0] word_q [$];
	logic [data_w-1:0] flit_q [$];
	int                flits_in;
	int                flits_out;
	logic              route_locked;
	int                locked_port;
	int                lat_cnt;
	logic              rst_seen;
	logic              post_rst;
	logic              rdy_low_seen;

	dispatch_top #(
		.data_w    (data_w),
		.fifo_depth(fifo_depth),
		.port_count(port_count)
	) dut0 (
		.clk       (clk),
		.rst       (rst),
		.host_wdata(host_wdata),
		.host_wen  (host_wen),
		.host_rdy  (host_rdy),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.out_id    (out_id),
		.out_dest  (out_dest),
		.out_keep  (out_keep),
		.out_strb  (out_strb),
		.out_user  (out_user),
		.out_last  (out_last)
	);

	always #(clk_period / 2) clk = ~clk;

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [data_w-1:0] got,
			input logic [data_w-1:0] exp);
		assert (got === exp)
		else fail_run($sformatf("error at %0d ns: %s is %0h, expected %0h",
			$time, name, got, exp));
	endtask

	task automatic drive_host_word();
		rng = xorshift(rng);
		host_wen   = (rng[2:0] != 3'd0);
		host_wdata = byte_w'(rng >> 8);
		host_wdata[byte_w-1] = (rng[25:24] == 2'd0); // Ends a packet in lane seven
	endtask

	task automatic drive_port_ready();
		int p;
		for (p = 0; p < port_count; p++) begin
			rng = xorshift(rng);
			out_ready[p] = (rng[1:0] != 2'd0);
		end
	endtask

	// ========================================
	// Model and checks
	// ========================================

	always @(posedge clk) begin
		logic [data_w-1:0]     exp_flit;
		logic [data_w-1:0]     new_flit;
		logic [port_count-1:0] exp_valid;
		int                    exp_port;
		int                    i;
		if (rst) begin
			if (rst_seen) begin
				check_value("out_valid", data_w'(out_valid), '0);
				check_value("host_rdy", data_w'(host_rdy), data_w'(1));
			end
			rst_seen = 1'b1;
			post_rst = 1'b1;
		end else begin
			if (post_rst) begin
				check_value("out_valid", data_w'(out_valid), '0);
				check_value("host_rdy", data_w'(host_rdy), data_w'(1));
				post_rst = 1'b0;
			end
			if (lat_cnt == 1) begin
				assert (out_valid != '0)
				else fail_run("out_valid did not rise two cycles after the eighth word");
			end else if (lat_cnt > 1) begin
				check_value("out_valid", data_w'(out_valid), '0);
			end
			if (lat_cnt > 0)
				lat_cnt = lat_cnt - 1;

			if (out_valid != '0) begin
				assert (flit_q.size() != 0)
				else fail_run("out_valid is high with no accepted flit waiting");
				exp_flit = flit_q[0];
				// The first flit of a packet picks the port, the rest follow it
				exp_port = route_locked ? locked_port
					: int'(exp_flit[dest_lsb +: meta_w]) % port_count;
				exp_valid = port_count'(1) << exp_port;
				check_value("out_valid", data_w'(out_valid), data_w'(exp_valid));
				check_value("out_data", out_data, exp_flit);
				check_value("out_dest", data_w'(out_dest), data_w'(exp_flit[dest_lsb +: meta_w]));
				check_value("out_id", data_w'(out_id), data_w'(exp_flit[id_lsb +: meta_w]));
				check_value("out_keep", data_w'(out_keep), data_w'(exp_flit[keep_lsb +: byte_w]));
				check_value("out_strb", data_w'(out_strb),
					data_w'(exp_flit[keep_lsb + byte_w +: byte_w]));
				check_value("out_user", data_w'(out_user), data_w'(exp_flit[user_w-1:0]));
				check_value("out_last", data_w'(out_last), data_w'(exp_flit[data_w-1]));
				if ((out_valid & out_ready) != '0) begin
					void'(flit_q.pop_front());
					flits_out = flits_out + 1;
					route_locked = !exp_flit[data_w-1];
					locked_port  = exp_port;
				end
			end

			if (host_wen && host_rdy) begin
				word_q.push_back(host_wdata);
				if (word_q.size() == lanes_per_flit) begin
					for (i = 0; i < lanes_per_flit; i++)
						new_flit[i*byte_w +: byte_w] = word_q[i]; // First word in lane zero
					if (flit_q.size() == 0)
						lat_cnt = 2;
					flit_q.push_back(new_flit);
					word_q.delete();
					flits_in = flits_in + 1;
				end
			end
			if (stalling && !host_rdy)
				rdy_low_seen = 1'b1;
		end
	end

	// ========================================
	// Stimulus
	// ========================================

	initial begin
		rng          = 32'h5e94;
		rst          = 1'b1;
		host_wdata   = '0;
		host_wen     = 1'b0;
		out_ready    = '0;
		stalling     = 1'b0;
		stall_left   = stall_len;
		flits_in     = 0;
		flits_out    = 0;
		route_locked = 1'b0;
		locked_port  = 0;
		lat_cnt      = 0;
		rst_seen     = 1'b0;
		post_rst     = 1'b0;
		rdy_low_seen = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (flits_in < n_flits) begin
			drive_host_word();
			if (flits_in >= stall_at && stall_left > 0) begin
				stalling   = 1'b1; // All ports blocked so the FIFO fills up
				out_ready  = '0;
				stall_left = stall_left - 1;
			end else begin
				stalling = 1'b0;
				drive_port_ready();
			end
			@(negedge clk);
		end
		host_wen  = 1'b0;
		stalling  = 1'b0;
		out_ready = '1;
		while (flit_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		check_value("out_valid", data_w'(out_valid), '0);
		assert (rdy_low_seen)
		else fail_run("host_rdy never dropped during the stall phase");
		$display("Done: no errors");
		$finish;
	end

	// Limit scales with the flit count and a generous cycle budget per flit
	initial begin
		#(run_limit * 1ns);
		fail_run($sformatf("timeout: only %0d of %0d flits delivered", flits_out, n_flits));
	end

endmodule

// ==== source/dispatch_top.sv ====
`timescale 1ns/100ps

module dispatch_top #(
	parameter int data_w = 128,
	parameter int fifo_depth = 16,
	parameter int port_count = 4,
	localparam int byte_w = data_w / 8
)(
	input  logic                            clk,
	input  logic                            rst,
	// Host write side
	input  logic [byte_w-1:0]               host_wdata,
	input  logic                            host_wen,
	output logic                            host_rdy,
	// Routed output ports
	output logic [port_count-1:0]           out_valid,
	input  logic [port_count-1:0]           out_ready,
	output logic [data_w-1:0]               out_data,
	output logic [dispatch_pkg::meta_w-1:0] out_id,
	output logic [dispatch_pkg::meta_w-1:0] out_dest,
	output logic [byte_w-1:0]               out_keep,
	output logic [byte_w-1:0]               out_strb,
	output logic [dispatch_pkg::user_w-1:0] out_user,
	output logic                            out_last
);

	logic                            flit_push;
	logic [data_w-1:0]               flit_data;
	logic                            flit_room;

	logic                            tx_tvalid;
	logic [data_w-1:0]               tx_tdata;
	logic [dispatch_pkg::meta_w-1:0] tx_tid;
	logic [dispatch_pkg::meta_w-1:0] tx_tdest;
	logic [byte_w-1:0]               tx_tkeep;
	logic [byte_w-1:0]               tx_tstrb;
	logic [dispatch_pkg::user_w-1:0] tx_tuser;
	logic                            tx_tlast;
	logic                            tx_tready;

	word_assembler #(
		.data_w(data_w)
	) assembler0 (
		.clk       (clk),
		.rst       (rst),
		.host_wdata(host_wdata),
		.host_wen  (host_wen),
		.host_rdy  (host_rdy),
		.flit_room (flit_room),
		.flit_push (flit_push),
		.flit_data (flit_data)
	);

	dispatcher #(
		.data_w    (data_w),
		.fifo_depth(fifo_depth)
	) dispatcher0 (
		.clk      (clk),
		.rst      (rst),
		.flit_push(flit_push),
		.flit_data(flit_data),
		.flit_room(flit_room),
		.tx_tvalid(tx_tvalid),
		.tx_tdata (tx_tdata),
		.tx_tid   (tx_tid),
		.tx_tdest (tx_tdest),
		.tx_tkeep (tx_tkeep),
		.tx_tstrb (tx_tstrb),
		.tx_tuser (tx_tuser),
		.tx_tlast (tx_tlast),
		.tx_tready(tx_tready)
	);

	dest_router #(
		.data_w    (data_w),
		.port_count(port_count)
	) router0 (
		.clk      (clk),
		.rst      (rst),
		.tx_tvalid(tx_tvalid),
		.tx_tdata (tx_tdata),
		.tx_tid   (tx_tid),
		.tx_tdest (tx_tdest),
		.tx_tkeep (tx_tkeep),
		.tx_tstrb (tx_tstrb),
		.tx_tuser (tx_tuser),
		.tx_tlast (tx_tlast),
		.tx_tready(tx_tready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data (out_data),
		.out_id   (out_id),
		.out_dest (out_dest),
		.out_keep (out_keep),
		.out_strb (out_strb),
		.out_user (out_user),
		.out_last (out_last)
	);

endmodule

// ==== source/dest_router.sv ====
`timescale 1ns/100ps

module dest_router #(
	parameter int data_w = 128,
	parameter int port_count = 4,
	localparam int byte_w = data_w / 8
)(
	input  logic                            clk,
	input  logic                            rst,
	// Tx stream from the dispatcher
	input  logic                            tx_tvalid,
	input  logic [data_w-1:0]               tx_tdata,
	input  logic [dispatch_pkg::meta_w-1:0] tx_tid,
	input  logic [dispatch_pkg::meta_w-1:0] tx_tdest,
	input  logic [byte_w-1:0]               tx_tkeep,
	input  logic [byte_w-1:0]               tx_tstrb,
	input  logic [dispatch_pkg::user_w-1:0] tx_tuser,
	input  logic                            tx_tlast,
	output logic                            tx_tready,
	// Output ports, one valid and ready per port over shared buses
	output logic [port_count-1:0]           out_valid,
	input  logic [port_count-1:0]           out_ready,
	output logic [data_w-1:0]               out_data,
	output logic [dispatch_pkg::meta_w-1:0] out_id,
	output logic [dispatch_pkg::meta_w-1:0] out_dest,
	output logic [byte_w-1:0]               out_keep,
	output logic [byte_w-1:0]               out_strb,
	output logic [dispatch_pkg::user_w-1:0] out_user,
	output logic                            out_last
);

	localparam int sel_w = $clog2(port_count);

	logic             locked;
	logic [sel_w-1:0] lock_port;
	logic [sel_w-1:0] sel;
	logic             xfer;

	// Mid-packet flits follow the port of the first flit
	assign sel  = locked ? lock_port : tx_tdest[sel_w-1:0];
	assign xfer = tx_tvalid && tx_tready;

	assign out_valid = port_count'(tx_tvalid) << sel;
	assign tx_tready = out_ready[sel];

	assign out_data = tx_tdata;
	assign out_id   = tx_tid;
	assign out_dest = tx_tdest;
	assign out_keep = tx_tkeep;
	assign out_strb = tx_tstrb;
	assign out_user = tx_tuser;
	assign out_last = tx_tlast;

	// ========================================
	// Route lock
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			locked    <= 1'b0;
			lock_port <= '0;
		end else if (xfer) begin
			if (tx_tlast) begin
				locked <= 1'b0; // Packet done, next flit picks a new port
			end else begin
				locked    <= 1'b1;
				lock_port <= sel;
			end
		end
	end

	// A stalled flit keeps its port until it is taken
	a_route_held: assert property (@(posedge clk) disable iff (rst)
		tx_tvalid && !tx_tready |=> out_valid == $past(out_valid))
		else $error("stalled flit moved to another output port");

endmodule

// ==== source/dispatcher.sv ====
`timescale 1ns/100ps

module dispatcher #(
	parameter int data_w = 128,
	parameter int fifo_depth = 16,
	localparam int byte_w = data_w / 8
)(
	input  logic                            clk,
	input  logic                            rst,
	// Flits from the assembler
	input  logic                            flit_push,
	input  logic [data_w-1:0]               flit_data,
	output logic                            flit_room,
	// Tx stream
	output logic                            tx_tvalid,
	output logic [data_w-1:0]               tx_tdata,
	output logic [dispatch_pkg::meta_w-1:0] tx_tid,
	output logic [dispatch_pkg::meta_w-1:0] tx_tdest,
	output logic [byte_w-1:0]               tx_tkeep,
	output logic [byte_w-1:0]               tx_tstrb,
	output logic [dispatch_pkg::user_w-1:0] tx_tuser,
	output logic                            tx_tlast,
	input  logic                            tx_tready
);

	import dispatch_pkg::*;

	localparam int strb_lsb = keep_lsb + byte_w;

	logic [data_w-1:0] head_word;
	logic              fifo_empty;
	logic              fifo_full;

	sync_fifo #(
		.width(data_w),
		.depth(fifo_depth)
	) flit_fifo (
		.clk  (clk),
		.rst  (rst),
		.push (flit_push),
		.idata(flit_data),
		.pop  (tx_tvalid && tx_tready),
		.odata(head_word),
		.empty(fifo_empty),
		.full (fifo_full)
	);

	assign flit_room = !fifo_full;
	assign tx_tvalid = !fifo_empty;

	// ========================================
	// Field views of the head flit
	// ========================================

	assign tx_tdata = head_word;
	assign tx_tdest = head_word[dest_lsb +: meta_w];
	assign tx_tid   = head_word[id_lsb +: meta_w];
	assign tx_tkeep = head_word[keep_lsb +: byte_w];
	assign tx_tstrb = head_word[strb_lsb +: byte_w];
	assign tx_tuser = head_word[user_w-1:0]; // Overlaps dest and id
	assign tx_tlast = head_word[data_w-1];

	// A stalled head must not move until the router takes it
	a_stall_stable: assert property (@(posedge clk) disable iff (rst)
		tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata))
		else $error("tx stream changed while stalled");

endmodule

// ==== source/word_assembler.sv ====
`timescale 1ns/100ps

module word_assembler #(
	parameter int data_w = 128,
	localparam int byte_w = data_w / dispatch_pkg::lanes_per_flit
)(
	input  logic              clk,
	input  logic              rst,
	input  logic [byte_w-1:0] host_wdata,
	input  logic              host_wen,
	output logic              host_rdy,
	input  logic              flit_room,
	output logic              flit_push,
	output logic [data_w-1:0] flit_data
);

	import dispatch_pkg::*;

	localparam int lane_w = $clog2(lanes_per_flit);
	localparam int held_w = data_w - byte_w;

	logic [lane_w-1:0] lane_cnt;
	logic [held_w-1:0] held; // Lanes zero to six of the flit being built
	logic              last_lane;
	logic              accept;

	assign last_lane = (lane_cnt == lane_w'(lanes_per_flit - 1));

	// Only the closing word has to wait for room in the FIFO
	assign host_rdy = !(last_lane && !flit_room);
	assign accept   = host_wen && host_rdy;

	// ========================================
	// Lane counter and push strobe
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			lane_cnt  <= '0;
			flit_push <= 1'b0;
		end else begin
			flit_push <= accept && last_lane;
			if (accept) begin
				if (last_lane)
					lane_cnt <= '0;
				else
					lane_cnt <= lane_cnt + 1'b1;
			end
		end
	end

	// ========================================
	// Lane packing
	// ========================================

	// Words enter at the top and shift down, so after seven words the
	// first one lands in lane zero
	always_ff @(posedge clk) begin
		if (accept) begin
			if (last_lane)
				flit_data <= {host_wdata, held};
			else
				held <= {host_wdata, held[held_w-1:byte_w]};
		end
	end

	// The room level comes from the dispatcher FIFO one stage further on
	a_push_has_room: assert property (@(posedge clk) disable iff (rst)
		flit_push |-> flit_room)
		else $error("flit pushed while the dispatcher FIFO had no room");

endmodule

// ==== source/sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
	parameter int width = 128,
	parameter int depth = 16
)(
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic [width-1:0] idata,
	input  logic             pop,
	output logic [width-1:0] odata,
	output logic             empty,
	output logic             full
);

	localparam int addr_w = $clog2(depth);

	logic [width-1:0]  mem [0:depth-1];
	logic [addr_w-1:0] head;
	logic [addr_w-1:0] tail;
	logic [addr_w-1:0] tail_next;

	assign tail_next = tail + 1'b1;

	// One slot is always left free so full and empty stay distinct
	assign empty = (tail == head);
	assign full  = (tail_next == head);

	assign odata = mem[head]; // Head entry is read without a register stage

	// ========================================
	// Pointers
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
		end else begin
			if (push)
				tail <= tail_next;
			if (pop)
				head <= head + 1'b1;
		end
	end

	// ========================================
	// Storage
	// ========================================

	always_ff @(posedge clk) begin
		if (push)
			mem[tail] <= idata;
	end

	// Producer and consumer are expected to respect the flags
	a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full)
		else $error("sync_fifo push while full");

	a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
		else $error("sync_fifo pop while empty");

endmodule

// ==== source/dispatch_pkg.sv ====
package dispatch_pkg;

	// ========================================
	// Metadata widths
	// ========================================

	// The id and dest fields share one width
	localparam int meta_w = 8;

	// User view of the flit, taken from its low bits
	localparam int user_w = 32;

	// Host words packed into one flit
	localparam int lanes_per_flit = 8;

	// ========================================
	// Flit field positions
	// ========================================

	// Routing byte sits at the very bottom of the flit
	localparam int dest_lsb = 0;
	localparam int id_lsb   = meta_w;

	// keep starts after one unused meta-sized gap
	localparam int keep_lsb = 3 * meta_w;

	// strb follows keep directly, so its position depends on the flit width.
	// tlast is always the top bit, and tuser overlaps dest and id

endpackage
